//--- common/dm_pkg.sv
/*
  Shared sizes, encodings and DMI transfer types for the JTAG DTM.
  DMI scan layout is {addr, data, op} with op in the two LSBs.
  Address width is fixed at ABITS and is also reported through DTMCS.
  Only opcodes NOP, READ and WRITE are defined; code 3 is reserved.
*/
`default_nettype none

package dm_pkg;

  // --------------------------------------------------
  // TAP and instruction register
  // --------------------------------------------------
  localparam int unsigned IR_LENGTH = 5;

  // Bit 0 must be one for a valid IDCODE
  localparam logic [31:0] IDCODE_VALUE = 32'h1000_2A53;

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE, SELECT_DR_SCAN,
    CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR,
    UPDATE_DR, SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR,
    EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_e;

  typedef enum logic [IR_LENGTH-1:0] {
    BYPASS0   = 5'h00,
    IDCODE    = 5'h01,
    DTMCSR    = 5'h10,
    DMIACCESS = 5'h11,
    BYPASS1   = 5'h1f
  } ir_e;

  // --------------------------------------------------
  // DTMCS and DMI
  // --------------------------------------------------
  localparam int unsigned ABITS = 7;

  // idle hint 1, dmistat 0, abits, version 1 (spec 0.13)
  localparam logic [31:0] DTMCS_VALUE = {17'd0, 3'd1, 2'd0, 6'(ABITS), 4'd1};

  // Writing one here clears the stored DMI response
  localparam int unsigned DTMCS_DMIRESET_BIT = 16;

  typedef enum logic [1:0] {
    DMI_OP_NOP   = 2'h0,
    DMI_OP_READ  = 2'h1,
    DMI_OP_WRITE = 2'h2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DMI_RESP_OK     = 2'h0,
    DMI_RESP_FAILED = 2'h2
  } dmi_resp_e;

  typedef struct packed {
    logic [ABITS-1:0] addr;
    logic [31:0]      data;
    dmi_op_e          op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_resp_e   resp;
  } dmi_resp_t;

  // Address plus 32 data bits plus 2 op bits
  localparam int unsigned DMI_WIDTH = ABITS + 34;

  // --------------------------------------------------
  // Request queue and register file
  // --------------------------------------------------
  localparam int unsigned QUEUE_DEPTH = 2;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned NUM_DM_REGS = 16;
  localparam int unsigned REG_IDX_W   = $clog2(NUM_DM_REGS);

endpackage

`default_nettype wire

//--- flist.f
common/dm_pkg.sv
jtag_tap/dmi_jtag_tap.sv
source/dmi_jtag_dr.sv
source/dmi_req_queue.sv
source/dm_regfile.sv
source/dmi_jtag.sv
testbench/dmi_jtag_sva.sv
testbench/tb_dmi_jtag.sv

//--- jtag_tap/dmi_jtag_tap.sv
/*
  IEEE 1149.1 TAP controller for the RISC-V debug transport (spec 0.13).
  Async reset lands in Run-Test-Idle with IDCODE selected.
  Unknown instructions select BYPASS.
  TDO is registered on the falling edge of TCK; no output enable is provided.
  DR strobes are plain state decodes, one TCK cycle per state visit.
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag_tap (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  // Strobes and data towards the DR block
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic update_dr_o,
  output logic tdi_o,
  output logic dtmcs_select_o,
  output logic dmi_select_o,
  output logic dmi_clear_o,
  // Serial outputs of the DR block
  input  logic dtmcs_tdo_i,
  input  logic dmi_tdo_i
);
  import dm_pkg::*;

  tap_state_e tap_state_q, tap_state_d;

  logic capture_ir, shift_ir, update_ir;
  logic test_logic_reset;

  logic [IR_LENGTH-1:0] ir_shift_q;
  ir_e                  ir_q;

  logic [31:0] idcode_q;
  logic        bypass_q;
  logic        idcode_select, bypass_select;
  logic        tdo_mux;

  // --------------------------------------------------
  // TAP FSM
  // --------------------------------------------------
  always_comb begin
    tap_state_d = tap_state_q;
    unique case (tap_state_q)
      TEST_LOGIC_RESET: tap_state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    tap_state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      // DR column
      SELECT_DR_SCAN:   tap_state_d = tms_i ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       tap_state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         tap_state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         tap_state_d = tms_i ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         tap_state_d = tms_i ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         tap_state_d = tms_i ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        tap_state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      // IR column
      SELECT_IR_SCAN:   tap_state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       tap_state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         tap_state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         tap_state_d = tms_i ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         tap_state_d = tms_i ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         tap_state_d = tms_i ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        tap_state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
    endcase
  end

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      tap_state_q <= RUN_TEST_IDLE;
    end else begin
      tap_state_q <= tap_state_d;
    end
  end

  // State decodes
  assign test_logic_reset = (tap_state_q == TEST_LOGIC_RESET);
  assign capture_ir       = (tap_state_q == CAPTURE_IR);
  assign shift_ir         = (tap_state_q == SHIFT_IR);
  assign update_ir        = (tap_state_q == UPDATE_IR);

  // --------------------------------------------------
  // Instruction register
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      ir_shift_q <= '0;
      ir_q       <= IDCODE;
    end else if (test_logic_reset) begin
      ir_shift_q <= '0;
      ir_q       <= IDCODE;
    end else begin
      // Fixed capture pattern, two LSBs are 01 as the standard requires
      if (capture_ir) begin
        ir_shift_q <= 5'b00101;
      end else if (shift_ir) begin
        ir_shift_q <= {td_i, ir_shift_q[IR_LENGTH-1:1]};
      end
      if (update_ir) begin
        ir_q <= ir_e'(ir_shift_q);
      end
    end
  end

  // Instruction decode, anything unknown falls back to BYPASS
  always_comb begin
    idcode_select  = 1'b0;
    bypass_select  = 1'b0;
    dtmcs_select_o = 1'b0;
    dmi_select_o   = 1'b0;
    unique case (ir_q)
      IDCODE:    idcode_select  = 1'b1;
      DTMCSR:    dtmcs_select_o = 1'b1;
      DMIACCESS: dmi_select_o   = 1'b1;
      default:   bypass_select  = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // IDCODE and BYPASS data registers
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      idcode_q <= IDCODE_VALUE;
      bypass_q <= 1'b0;
    end else if (test_logic_reset) begin
      idcode_q <= IDCODE_VALUE;
      bypass_q <= 1'b0;
    end else begin
      if (capture_dr_o && idcode_select) begin
        idcode_q <= IDCODE_VALUE;
      end else if (shift_dr_o && idcode_select) begin
        idcode_q <= {td_i, idcode_q[31:1]};
      end
      // Bypass captures zero, then delays TDI by one bit
      if (capture_dr_o && bypass_select) begin
        bypass_q <= 1'b0;
      end else if (shift_dr_o && bypass_select) begin
        bypass_q <= td_i;
      end
    end
  end

  // --------------------------------------------------
  // TDO
  // --------------------------------------------------
  always_comb begin
    if (shift_ir) begin
      tdo_mux = ir_shift_q[0];
    end else if (idcode_select) begin
      tdo_mux = idcode_q[0];
    end else if (dtmcs_select_o) begin
      tdo_mux = dtmcs_tdo_i;
    end else if (dmi_select_o) begin
      tdo_mux = dmi_tdo_i;
    end else begin
      tdo_mux = bypass_q;
    end
  end

  // Launch on falling edge so the host samples a stable bit on the rising edge
  always_ff @(negedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      td_o <= 1'b0;
    end else begin
      td_o <= tdo_mux;
    end
  end

  // Strobes for the DR block
  assign capture_dr_o = (tap_state_q == CAPTURE_DR);
  assign shift_dr_o   = (tap_state_q == SHIFT_DR);
  assign update_dr_o  = (tap_state_q == UPDATE_DR);
  assign tdi_o        = td_i;
  assign dmi_clear_o  = test_logic_reset;

endmodule

`default_nettype wire

//--- source/dm_regfile.sv
/*
  Stand-in debug module: 16 words of 32 bits behind the DMI.
  Takes one request per cycle and never stalls.
  Out-of-range addresses answer FAILED with zero data.
  Response appears one cycle after the pop.
*/
`timescale 1ns/1ps
`default_nettype none

module dm_regfile (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               empty_i,
  input  dm_pkg::dmi_req_t   req_i,
  output logic               pop_o,
  output logic               resp_valid_o,
  output dm_pkg::dmi_resp_t  resp_o
);
  import dm_pkg::*;

  logic [31:0]          regs_q [NUM_DM_REGS];
  logic                 in_range;
  logic [REG_IDX_W-1:0] idx;

  // Always ready, so pop whenever something is queued
  assign pop_o = !empty_i;

  assign in_range = (req_i.addr < ABITS'(NUM_DM_REGS));
  assign idx      = req_i.addr[REG_IDX_W-1:0];

  // --------------------------------------------------
  // Register array
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      for (int i = 0; i < NUM_DM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (pop_o && in_range && req_i.op == DMI_OP_WRITE) begin
      regs_q[idx] <= req_i.data;
    end
  end

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      resp_valid_o <= 1'b0;
      resp_o       <= '{data: '0, resp: DMI_RESP_OK};
    end else begin
      resp_valid_o <= pop_o;
      if (pop_o) begin
        if (!in_range) begin
          resp_o <= '{data: '0, resp: DMI_RESP_FAILED};
        end else if (req_i.op == DMI_OP_WRITE) begin
          // Writes echo the written data
          resp_o <= '{data: req_i.data, resp: DMI_RESP_OK};
        end else if (req_i.op == DMI_OP_READ) begin
          resp_o <= '{data: regs_q[idx], resp: DMI_RESP_OK};
        end else begin
          resp_o <= '{data: '0, resp: DMI_RESP_OK};
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/dmi_jtag.sv
/*
  JTAG debug transport top level.
  Single TCK domain; TAP, DR block, request queue and register file.
  No output enable; td_o is always driven.
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o
);
  import dm_pkg::*;

  // TAP to DR block
  logic capture_dr, shift_dr, update_dr, tdi;
  logic dtmcs_select, dmi_select, dmi_clear;
  logic dtmcs_tdo, dmi_tdo;

  // DR block to queue
  logic     push, full;
  dmi_req_t push_req;

  // Queue to register file and back
  logic      empty, pop, resp_valid;
  dmi_req_t  pop_req;
  dmi_resp_t resp;

  dmi_jtag_tap tap_inst (
    .tck_i          (tck_i),
    .trst_ni        (trst_ni),
    .tms_i          (tms_i),
    .td_i           (td_i),
    .td_o           (td_o),
    .capture_dr_o   (capture_dr),
    .shift_dr_o     (shift_dr),
    .update_dr_o    (update_dr),
    .tdi_o          (tdi),
    .dtmcs_select_o (dtmcs_select),
    .dmi_select_o   (dmi_select),
    .dmi_clear_o    (dmi_clear),
    .dtmcs_tdo_i    (dtmcs_tdo),
    .dmi_tdo_i      (dmi_tdo)
  );

  dmi_jtag_dr dr_inst (
    .tck_i          (tck_i),
    .trst_ni        (trst_ni),
    .tdi_i          (tdi),
    .capture_dr_i   (capture_dr),
    .shift_dr_i     (shift_dr),
    .update_dr_i    (update_dr),
    .dtmcs_select_i (dtmcs_select),
    .dmi_select_i   (dmi_select),
    .dmi_clear_i    (dmi_clear),
    .full_i         (full),
    .push_o         (push),
    .push_req_o     (push_req),
    .resp_valid_i   (resp_valid),
    .resp_i         (resp),
    .dtmcs_tdo_o    (dtmcs_tdo),
    .dmi_tdo_o      (dmi_tdo)
  );

  // TAP reset also flushes pending requests
  dmi_req_queue queue_inst (
    .tck_i      (tck_i),
    .trst_ni    (trst_ni),
    .clear_i    (dmi_clear),
    .push_i     (push),
    .push_req_i (push_req),
    .pop_i      (pop),
    .full_o     (full),
    .empty_o    (empty),
    .pop_req_o  (pop_req)
  );

  dm_regfile regfile_inst (
    .tck_i        (tck_i),
    .trst_ni      (trst_ni),
    .empty_i      (empty),
    .req_i        (pop_req),
    .pop_o        (pop),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

endmodule

`default_nettype wire

//--- source/dmi_jtag_dr.sv
/*
  DTMCS and DMI data registers of the debug transport.
  Both shift LSB first. A DMI update with a non-NOP op pushes a request;
  it is dropped when the queue is full and no busy status is reported.
  A response arriving in the Capture-DR cycle is forwarded into the scan.
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag_dr (
  input  logic                tck_i,
  input  logic                trst_ni,
  input  logic                tdi_i,
  input  logic                capture_dr_i,
  input  logic                shift_dr_i,
  input  logic                update_dr_i,
  input  logic                dtmcs_select_i,
  input  logic                dmi_select_i,
  input  logic                dmi_clear_i,
  // Queue side
  input  logic                full_i,
  output logic                push_o,
  output dm_pkg::dmi_req_t    push_req_o,
  // Response from the register file
  input  logic                resp_valid_i,
  input  dm_pkg::dmi_resp_t   resp_i,
  // Serial outputs to the TAP
  output logic                dtmcs_tdo_o,
  output logic                dmi_tdo_o
);
  import dm_pkg::*;

  logic [31:0]          dtmcs_q;
  logic [DMI_WIDTH-1:0] dmi_q;
  dmi_resp_t            resp_q;
  dmi_resp_t            capture_resp;
  logic                 dmi_reset;

  // --------------------------------------------------
  // DTMCS
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      dtmcs_q <= '0;
    end else if (dtmcs_select_i) begin
      if (capture_dr_i) begin
        dtmcs_q <= DTMCS_VALUE;
      end else if (shift_dr_i) begin
        dtmcs_q <= {tdi_i, dtmcs_q[31:1]};
      end
    end
  end

  // Only dmireset is writable, everything else reads back fixed
  assign dmi_reset = update_dr_i && dtmcs_select_i && dtmcs_q[DTMCS_DMIRESET_BIT];

  // --------------------------------------------------
  // DMI access
  // --------------------------------------------------
  // Response may still be in flight during Capture-DR
  assign capture_resp = resp_valid_i ? resp_i : resp_q;

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      dmi_q <= '0;
    end else if (dmi_select_i) begin
      if (capture_dr_i) begin
        // Address field reads back zero
        dmi_q <= {{ABITS{1'b0}}, capture_resp};
      end else if (shift_dr_i) begin
        dmi_q <= {tdi_i, dmi_q[DMI_WIDTH-1:1]};
      end
    end
  end

  // Request decode straight from the shifted bits
  assign push_req_o = dmi_req_t'(dmi_q);
  assign push_o     = update_dr_i && dmi_select_i && !full_i
                      && (push_req_o.op != DMI_OP_NOP);

  // --------------------------------------------------
  // Stored response
  // --------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      resp_q <= '{data: '0, resp: DMI_RESP_OK};
    end else if (dmi_clear_i || dmi_reset) begin
      resp_q <= '{data: '0, resp: DMI_RESP_OK};
    end else if (resp_valid_i) begin
      resp_q <= resp_i;
    end
  end

  // Serial outputs
  assign dtmcs_tdo_o = dtmcs_q[0];
  assign dmi_tdo_o   = dmi_q[0];

endmodule

`default_nettype wire

//--- source/dmi_req_queue.sv
/*
  Two-entry FIFO of DMI requests.
  Push when full and pop when empty are ignored.
  Read data is valid whenever empty_o is low.
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_req_queue (
  input  logic              tck_i,
  input  logic              trst_ni,
  input  logic              clear_i,
  input  logic              push_i,
  input  dm_pkg::dmi_req_t  push_req_i,
  input  logic              pop_i,
  output logic              full_o,
  output logic              empty_o,
  output dm_pkg::dmi_req_t  pop_req_o
);
  import dm_pkg::*;

  dmi_req_t               mem_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [QUEUE_PTR_W:0]   count_q;
  logic                   do_push, do_pop;

  assign full_o  = (count_q == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
  assign empty_o = (count_q == '0);

  // Qualified strobes
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  assign pop_req_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- testbench/dmi_jtag_sva.sv
/*
  Concurrent checks bound into the DTM top level.
  Each failure bumps error_count, which the testbench polls.
  Checks are disabled while trst_ni is low, except the reset exit check.
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag_sva (
  input logic tck_i,
  input logic trst_ni,
  input logic tdo_i,
  input logic dtmcs_select_i,
  input logic dmi_select_i,
  input logic update_dr_i,
  input logic push_i,
  input logic full_i,
  input logic pop_i,
  input logic resp_valid_i
);
  int unsigned error_count = 0;

  // --------------------------------------------------
  // Instruction decode and queue
  // --------------------------------------------------
  select_onehot_a: assert property (@(posedge tck_i) disable iff (!trst_ni)
    !(dtmcs_select_i && dmi_select_i))
    else begin
      error_count++;
      $error("DTMCS and DMI selected at the same time");
    end

  // A DMI update never meets a full queue, so no request is dropped
  push_not_full_a: assert property (@(posedge tck_i) disable iff (!trst_ni)
    (update_dr_i && dmi_select_i) |-> !full_i)
    else begin
      error_count++;
      $error("DMI update while the request queue is full");
    end

  // Queued request is popped next cycle and answered one cycle after the pop
  resp_latency_a: assert property (@(posedge tck_i) disable iff (!trst_ni)
    push_i |=> pop_i ##1 resp_valid_i)
    else begin
      error_count++;
      $error("resp_valid does not follow pop by one cycle");
    end

  // --------------------------------------------------
  // Reset exit
  // --------------------------------------------------
  tdo_reset_a: assert property (@(posedge tck_i) $rose(trst_ni) |-> !tdo_i)
    else begin
      error_count++;
      $error("TDO not low in the first cycle after reset");
    end

endmodule

bind dmi_jtag dmi_jtag_sva sva_inst (
  .tck_i          (tck_i),
  .trst_ni        (trst_ni),
  .tdo_i          (td_o),
  .dtmcs_select_i (dtmcs_select),
  .dmi_select_i   (dmi_select),
  .update_dr_i    (update_dr),
  .push_i         (push),
  .full_i         (full),
  .pop_i          (pop),
  .resp_valid_i   (resp_valid)
);

`default_nettype wire

//--- testbench/tb_dmi_jtag.sv
/*
  Testbench for the JTAG DTM top level.
  TMS and TDI change on the falling edge, TDO is sampled on the rising edge.
  Every scan starts and ends in Run-Test-Idle.
  Write data comes from a 32-bit Fibonacci LFSR, x^32+x^22+x^2+x+1.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dmi_jtag;
  import dm_pkg::*;

  logic tck;
  logic trst_n;
  logic tms;
  logic tdi;
  logic tdo;

  logic [31:0] lfsr_state;
  logic [31:0] dtmcs_exp;
  int unsigned cycle_count = 0;

  dmi_jtag dmi_jtag_inst (
    .tck_i   (tck),
    .trst_ni (trst_n),
    .tms_i   (tms),
    .td_i    (tdi),
    .td_o    (tdo)
  );

  initial begin
    tck = 1'b0;
    forever #5 tck = ~tck;
  end

  // Scans total about 1600 cycles, limit at roughly twice that
  always @(posedge tck) begin
    cycle_count++;
    if (dmi_jtag_inst.sva_inst.error_count != 0) begin
      $display("Bound assertion failed before %0t ns", $time);
      $display("sim failed");
      $fatal(1, "assertion failure");
    end else if (cycle_count >= 4000) begin
      $display("Timeout: test did not finish within %0d cycles", cycle_count);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp)
      else begin
        $display("FAIL %0t ns: %s expected %h got %h", $time, what, exp, act);
        $display("sim failed");
        $fatal(1, "value mismatch");
      end
  endtask

  // Shift LSB first from Shift-xR, leaves in Exit1, then Update and Idle
  task automatic shift_bits(input int len, input logic [63:0] din, output logic [63:0] dout);
    dout = '0;
    for (int i = 0; i < len; i++) begin
      @(negedge tck);
      tdi = din[i];
      tms = (i == len - 1);
      @(posedge tck);
      dout[i] = tdo;
    end
    @(negedge tck);
    tms = 1'b1;
    @(negedge tck);
    tms = 1'b0;
    tdi = 1'b0;
  endtask

  task automatic dr_scan(input int len, input logic [63:0] din, output logic [63:0] dout);
    // Idle, Select-DR, Capture-DR, Shift-DR
    @(negedge tck);
    tms = 1'b1;
    @(negedge tck);
    tms = 1'b0;
    @(negedge tck);
    tms = 1'b0;
    shift_bits(len, din, dout);
  endtask

  task automatic ir_scan(input logic [4:0] ir, output logic [63:0] dout);
    // Idle, Select-DR, Select-IR, Capture-IR, Shift-IR
    @(negedge tck);
    tms = 1'b1;
    @(negedge tck);
    tms = 1'b1;
    @(negedge tck);
    tms = 1'b0;
    @(negedge tck);
    tms = 1'b0;
    shift_bits(IR_LENGTH, 64'(ir), dout);
  endtask

  // Five TMS ones reach Test-Logic-Reset from any state
  task automatic goto_reset();
    repeat (5) begin
      @(negedge tck);
      tms = 1'b1;
    end
    @(negedge tck);
    tms = 1'b0;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [63:0] dout;
    logic [31:0] wdata;
    tms        = 1'b0;
    tdi        = 1'b0;
    trst_n     = 1'b0;
    lfsr_state = 32'd70577;
    // version 1, abits, idle hint 1, dmistat 0
    dtmcs_exp        = '0;
    dtmcs_exp[3:0]   = 4'd1;
    dtmcs_exp[9:4]   = 6'(ABITS);
    dtmcs_exp[14:12] = 3'd1;
    repeat (4) @(negedge tck);
    // Falling-edge TDO flop still sees reset on this edge
    trst_n <= 1'b1;

    // IDCODE selected out of reset
    dr_scan(32, '0, dout);
    check_value("IDCODE after reset", 64'(IDCODE_VALUE), dout);

    // BYPASS delays TDI by one bit
    ir_scan(BYPASS1, dout);
    check_value("IR capture pattern", 64'h05, dout);
    random_word(wdata);
    dr_scan(16, 64'(wdata), dout);
    check_value("BYPASS data", 64'({wdata[14:0], 1'b0}), dout);

    ir_scan(DTMCSR, dout);
    dr_scan(32, '0, dout);
    check_value("DTMCS read", 64'(dtmcs_exp), dout);

    // Write, read, then NOP to fetch the read data
    ir_scan(DMIACCESS, dout);
    for (int a = 0; a < 16; a += 2) begin
      random_word(wdata);
      dr_scan(DMI_WIDTH, 64'({7'(a), wdata, DMI_OP_WRITE}), dout);
      dr_scan(DMI_WIDTH, 64'({7'(a), 32'h0, DMI_OP_READ}), dout);
      check_value("DMI write echo", 64'({7'd0, wdata, DMI_RESP_OK}), dout);
      dr_scan(DMI_WIDTH, '0, dout);
      check_value("DMI read data", 64'({7'd0, wdata, DMI_RESP_OK}), dout);
    end

    // Out of range read, then dmireset
    dr_scan(DMI_WIDTH, 64'({7'd20, 32'h0, DMI_OP_READ}), dout);
    dr_scan(DMI_WIDTH, '0, dout);
    check_value("DMI bad address", 64'({7'd0, 32'h0, DMI_RESP_FAILED}), dout);
    ir_scan(DTMCSR, dout);
    dr_scan(32, 64'h1 << DTMCS_DMIRESET_BIT, dout);
    check_value("DTMCS before dmireset", 64'(dtmcs_exp), dout);
    ir_scan(DMIACCESS, dout);
    dr_scan(DMI_WIDTH, '0, dout);
    check_value("DMI after dmireset", 64'({7'd0, 32'h0, DMI_RESP_OK}), dout);

    // Leave a nonzero response, then TAP reset must clear it
    random_word(wdata);
    dr_scan(DMI_WIDTH, 64'({7'd1, wdata, DMI_OP_WRITE}), dout);
    dr_scan(DMI_WIDTH, '0, dout);
    check_value("DMI write before TAP reset", 64'({7'd0, wdata, DMI_RESP_OK}), dout);
    goto_reset();
    dr_scan(32, '0, dout);
    check_value("IDCODE after TAP reset", 64'(IDCODE_VALUE), dout);
    ir_scan(DMIACCESS, dout);
    dr_scan(DMI_WIDTH, '0, dout);
    check_value("DMI after TAP reset", 64'({7'd0, 32'h0, DMI_RESP_OK}), dout);

    if (dmi_jtag_inst.sva_inst.error_count != 0) begin
      $display("Bound assertions failed %0d times", dmi_jtag_inst.sva_inst.error_count);
      $display("sim failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
